/* processor.f */
+incdir+hdl
hdl/processor_pkg.sv
hdl/pipe_reg.sv
hdl/register_bank.sv
hdl/fetch_decode.sv
hdl/execute_memory.sv
hdl/processor.sv
test/processor_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0 --timescale 1ns/100ps
TOP       := processor_tb
FILELIST  := processor.f

BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, so a crashed run without a pass line also fails.
run: compile
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q ">>> PASS" $(LOG); then echo "No result line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/processor_stimulus.txt */
// Records of three hex words: kind, address or register, value.
// Kind 1 program word, 2 expected retire, 3 expected data memory word, 4 cycle limit, 0 end.

// Program, loaded into instruction memory during reset.
1 00 51000005 // addi r1, r0, 5
1 01 5200FFFD // addi r2, r0, -3
1 02 03120000 // add  r3, r1, r2
1 03 14310000 // sub  r4, r3, r1
1 04 25410000 // and  r5, r4, r1
1 05 36520000 // or   r6, r5, r2
1 06 47630000 // xor  r7, r6, r3
1 07 70070004 // sw   r7, 4(r0)
1 08 68000004 // lw   r8, 4(r0)
1 09 59800001 // addi r9, r8, 1
1 0A 80000001 // bz   +1, taken
1 0B 5A000077 // addi r10, r0, 0x77, squashed
1 0C 90000001 // bnz  +1, not taken
1 0D 5A000007 // addi r10, r0, 7
1 0E 80000001 // bz   +1, not taken
1 0F A0000001 // bn   +1, not taken
1 10 1B0A0000 // sub  r11, r0, r10
1 11 A0000002 // bn   +2, taken
1 12 5C000055 // addi r12, r0, 0x55, squashed
1 13 5D000066 // addi r13, r0, 0x66, skipped
1 14 90000001 // bnz  +1, taken
1 15 5E000099 // addi r14, r0, 0x99, squashed
1 16 701B0003 // sw   r11, 3(r1)
1 17 6C100003 // lw   r12, 3(r1)
1 18 0DCC0000 // add  r13, r12, r12
1 19 700D0010 // sw   r13, 16(r0)
1 1A B0000000 // halt
1 1B 5F000042 // addi r15, r0, 0x42, never retires

// Retire trace in program order.
2 1 00000005
2 2 FFFFFFFD
2 3 00000002
2 4 FFFFFFFD
2 5 00000005
2 6 FFFFFFFD
2 7 FFFFFFFF
2 8 FFFFFFFF
2 9 00000000
2 A 00000007
2 B FFFFFFF9
2 C FFFFFFF9
2 D FFFFFFF2

// Data memory after halt.
3 04 FFFFFFFF
3 08 FFFFFFF9
3 10 FFFFFFF2

4 0 00000064
0 0 00000000

/* test/processor_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "processor_cfg.svh"

module processor_tb import processor_pkg::*; ();

	localparam int STIM_WORDS = 3 * (`PROC_IMEM_DEPTH + `PROC_DMEM_DEPTH + 8);
	localparam int RESET_CYCLES = 3;
	localparam int SETTLE_CYCLES = 4;

	logic clk;
	logic rst;
	logic im_we;
	imem_addr_t im_addr;
	word_t im_data;
	dmem_addr_t dbg_addr;
	word_t dbg_data;
	logic halted;
	logic retire_valid;
	reg_idx_t retire_rd;
	word_t retire_value;

	word_t stim [STIM_WORDS];
	imem_addr_t prog_addr_q [$];
	word_t prog_word_q [$];
	reg_idx_t exp_rd_q [$];
	word_t exp_value_q [$];
	dmem_addr_t mem_addr_q [$];
	word_t mem_word_q [$];

	int cycle_limit;
	int errors;
	int retires_seen;
	logic monitor_on;

	processor dut_i (
		.CLK          (clk),
		.rst          (rst),
		.im_we        (im_we),
		.im_addr      (im_addr),
		.im_data      (im_data),
		.dbg_addr     (dbg_addr),
		.dbg_data     (dbg_data),
		.halted       (halted),
		.retire_valid (retire_valid),
		.retire_rd    (retire_rd),
		.retire_value (retire_value)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ----------------------------------------------------------------------
	// Stimulus file and result checks
	// ----------------------------------------------------------------------

	task automatic load_stimulus();
		int i;
		word_t kind;
		logic done;
		$readmemh("test/processor_stimulus.txt", stim);
		i = 0;
		done = 1'b0;
		while (!done && (i + 2 < STIM_WORDS)) begin
			kind = stim[i];
			case (kind)
				32'd1: begin
					prog_addr_q.push_back(imem_addr_t'(stim[i + 1]));
					prog_word_q.push_back(stim[i + 2]);
				end
				32'd2: begin
					exp_rd_q.push_back(reg_idx_t'(stim[i + 1]));
					exp_value_q.push_back(stim[i + 2]);
				end
				32'd3: begin
					mem_addr_q.push_back(dmem_addr_t'(stim[i + 1]));
					mem_word_q.push_back(stim[i + 2]);
				end
				32'd4: cycle_limit = int'(stim[i + 2]);
				32'd0: done = 1'b1;
				default: begin
					errors++;
					$display("Unknown record kind %h in the stimulus file.", kind);
					done = 1'b1;
				end
			endcase
			i += 3;
		end
	endtask

	task automatic check_retire(input reg_idx_t rd, input word_t value);
		if (retires_seen >= exp_rd_q.size()) begin
			errors++;
			$display("Unexpected retire of r%0d = %h after the last expected one.", rd, value);
		end else begin
			if (rd !== exp_rd_q[retires_seen]) begin
				errors++;
				$display("** Error at %0t: retire %0d rd is r%0d, expected r%0d",
					$time, retires_seen, rd, exp_rd_q[retires_seen]);
			end
			if (value !== exp_value_q[retires_seen]) begin
				errors++;
				$display("** Error at %0t: retire %0d value is %h, expected %h",
					$time, retires_seen, value, exp_value_q[retires_seen]);
			end
		end
		retires_seen++;
	endtask

	task automatic check_mem(input dmem_addr_t addr, input word_t expected);
		@(posedge clk);
		dbg_addr <= addr;
		@(negedge clk);
		if (dbg_data !== expected) begin
			errors++;
			$display("** Error at %0t: dmem[%0d] is %h, expected %h",
				$time, addr, dbg_data, expected);
		end
	endtask

	task automatic check_level(input string what, input logic got, input logic expected);
		if (got !== expected) begin
			errors++;
			$display("** Error at %0t: %s is %b, expected %b", $time, what, got, expected);
		end
	endtask

	// Retire outputs change at the rising edge and are checked at the falling one.
	always @(negedge clk) begin
		if (monitor_on && retire_valid) begin
			check_retire(retire_rd, retire_value);
		end
	end

	// ----------------------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------------------

	initial begin
		int i;
		int cycles;
		errors = 0;
		retires_seen = 0;
		cycle_limit = 0;
		monitor_on = 1'b0;
		rst <= 1'b1;
		im_we <= 1'b0;
		im_addr <= '0;
		im_data <= '0;
		dbg_addr <= '0;
		load_stimulus();
		if ((prog_addr_q.size() == 0) || (cycle_limit == 0)) begin
			errors++;
			$display("The stimulus file holds no program or no cycle limit.");
		end

		// The program goes in through the load port while the core sits in reset.
		for (i = 0; i < prog_addr_q.size(); i++) begin
			@(posedge clk);
			im_we <= 1'b1;
			im_addr <= prog_addr_q[i];
			im_data <= prog_word_q[i];
		end
		@(posedge clk);
		im_we <= 1'b0;
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_level("retire_valid during reset", retire_valid, 1'b0);
			check_level("halted during reset", halted, 1'b0);
			@(posedge clk);
		end
		rst <= 1'b0;
		monitor_on = 1'b1;
		@(negedge clk);
		check_level("retire_valid after reset", retire_valid, 1'b0);
		check_level("halted after reset", halted, 1'b0);

		cycles = 1;
		while ((halted !== 1'b1) && (cycles < cycle_limit)) begin
			@(negedge clk);
			cycles++;
		end
		if (halted !== 1'b1) begin
			errors++;
			$display("Timeout: the core never halted within %0d cycles.", cycle_limit);
		end else begin
			// A few idle cycles let any retire after HALT show up.
			repeat (SETTLE_CYCLES) begin
				@(negedge clk);
			end
			for (i = 0; i < mem_addr_q.size(); i++) begin
				check_mem(mem_addr_q[i], mem_word_q[i]);
			end
		end

		@(posedge clk);
		if (retires_seen != exp_rd_q.size()) begin
			errors++;
			$display("Retire count is %0d, expected %0d.", retires_seen, exp_rd_q.size());
		end
		$display("Errors %0d, retires seen %0d, retires expected %0d",
			errors, retires_seen, exp_rd_q.size());
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/processor.sv */
`timescale 1ns/100ps
`default_nettype none

module processor import processor_pkg::*; (
	input  wire             CLK,
	input  wire             rst,
	input  wire             im_we,
	input  wire imem_addr_t im_addr,
	input  wire word_t      im_data,
	input  wire dmem_addr_t dbg_addr,
	output word_t           dbg_data,
	output logic            halted,
	output logic            retire_valid,
	output reg_idx_t        retire_rd,
	output word_t           retire_value
);

	logic redirect;
	imem_addr_t redirect_pc;
	reg_idx_t rs_idx;
	reg_idx_t rt_idx;
	word_t rs_val;
	word_t rt_val;
	logic dec_valid;
	ex_payload_t dec_payload;
	logic ex_valid;
	ex_payload_t ex_payload;
	logic res_valid;
	wb_payload_t res_payload;
	logic wb_valid;
	wb_payload_t wb_payload;

	// ----------------------------------------------------------------------
	// Fetch and decode
	// ----------------------------------------------------------------------

	fetch_decode fetch_decode_i (
		.CLK         (CLK),
		.rst         (rst),
		.im_we       (im_we),
		.im_addr     (im_addr),
		.im_data     (im_data),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.halted      (halted),
		.rs_idx      (rs_idx),
		.rt_idx      (rt_idx),
		.rs_val      (rs_val),
		.rt_val      (rt_val),
		.dec_valid   (dec_valid),
		.dec_payload (dec_payload)
	);

	register_bank register_bank_i (
		.CLK    (CLK),
		.rst    (rst),
		.rs_idx (rs_idx),
		.rt_idx (rt_idx),
		.rs_val (rs_val),
		.rt_val (rt_val),
		.wr_en  (retire_valid),
		.wr_idx (wb_payload.rd),
		.wr_val (wb_payload.value)
	);

	// A taken branch squashes the instruction fetched behind it.
	pipe_reg #(
		.payload_t (ex_payload_t)
	) decode_reg_i (
		.CLK         (CLK),
		.rst         (rst),
		.flush       (redirect),
		.in_valid    (dec_valid),
		.in_payload  (dec_payload),
		.out_valid   (ex_valid),
		.out_payload (ex_payload)
	);

	// ----------------------------------------------------------------------
	// Execute, memory and write-back
	// ----------------------------------------------------------------------

	execute_memory execute_memory_i (
		.CLK         (CLK),
		.rst         (rst),
		.ex_valid    (ex_valid),
		.ex_payload  (ex_payload),
		.wb_valid    (wb_valid),
		.wb_payload  (wb_payload),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.halted      (halted),
		.res_valid   (res_valid),
		.res_payload (res_payload),
		.dbg_addr    (dbg_addr),
		.dbg_data    (dbg_data)
	);

	pipe_reg #(
		.payload_t (wb_payload_t)
	) retire_reg_i (
		.CLK         (CLK),
		.rst         (rst),
		.flush       (1'b0),
		.in_valid    (res_valid),
		.in_payload  (res_payload),
		.out_valid   (wb_valid),
		.out_payload (wb_payload)
	);

	// Only entries that write a register show on the retire trace.
	assign retire_valid = wb_valid && wb_payload.wr;
	assign retire_rd = wb_payload.rd;
	assign retire_value = wb_payload.value;

endmodule

`default_nettype wire

/* hdl/execute_memory.sv */
`timescale 1ns/100ps
`default_nettype none

`include "processor_cfg.svh"

module execute_memory import processor_pkg::*; (
	input  wire              CLK,
	input  wire              rst,
	input  wire              ex_valid,
	input  wire ex_payload_t ex_payload,
	input  wire              wb_valid,
	input  wire wb_payload_t wb_payload,
	output logic             redirect,
	output imem_addr_t       redirect_pc,
	output logic             halted,
	output logic             res_valid,
	output wb_payload_t      res_payload,
	input  wire dmem_addr_t  dbg_addr,
	output word_t            dbg_data
);

	word_t dmem [`PROC_DMEM_DEPTH];
	word_t fwd_rs;
	word_t fwd_rt;
	word_t alu_b;
	word_t alu_y;
	word_t load_word;
	alu_op_e alu_op;
	dmem_addr_t mem_addr;
	logic is_alu;
	logic is_halt;
	logic taken;
	logic flag_z;
	logic flag_n;

	// ----------------------------------------------------------------------
	// Forwarding from write-back
	// ----------------------------------------------------------------------

	always_comb begin
		fwd_rs = ex_payload.rs_val;
		fwd_rt = ex_payload.rt_val;
		if (wb_valid && wb_payload.wr) begin
			if (wb_payload.rd == ex_payload.rs) begin
				fwd_rs = wb_payload.value;
			end
			if (wb_payload.rd == ex_payload.rt) begin
				fwd_rt = wb_payload.value;
			end
		end
	end

	// ----------------------------------------------------------------------
	// ALU
	// ----------------------------------------------------------------------

	always_comb begin
		alu_op = ALU_PASS_B;
		alu_b = fwd_rt;
		is_alu = 1'b1;
		case (ex_payload.op)
			OP_ADD: alu_op = ALU_ADD;
			OP_SUB: alu_op = ALU_SUB;
			OP_AND: alu_op = ALU_AND;
			OP_OR: alu_op = ALU_OR;
			OP_XOR: alu_op = ALU_XOR;
			OP_ADDI: begin
				alu_op = ALU_ADD;
				alu_b = ex_payload.imm;
			end
			// Loads and stores use the adder for rs plus immediate
			// but leave the flags alone.
			OP_LW, OP_SW: begin
				alu_op = ALU_ADD;
				alu_b = ex_payload.imm;
				is_alu = 1'b0;
			end
			default: is_alu = 1'b0;
		endcase
	end

	always_comb begin
		case (alu_op)
			ALU_ADD: alu_y = fwd_rs + alu_b;
			ALU_SUB: alu_y = fwd_rs - alu_b;
			ALU_AND: alu_y = fwd_rs & alu_b;
			ALU_OR: alu_y = fwd_rs | alu_b;
			ALU_XOR: alu_y = fwd_rs ^ alu_b;
			default: alu_y = alu_b;
		endcase
	end

	// ----------------------------------------------------------------------
	// Test flags, branches and halt
	// ----------------------------------------------------------------------

	assign is_halt = (ex_payload.op == OP_HALT);

	always_ff @(posedge CLK) begin
		if (rst) begin
			flag_z <= 1'b0;
			flag_n <= 1'b0;
			halted <= 1'b0;
		end else if (ex_valid) begin
			if (is_alu) begin
				flag_z <= (alu_y == '0);
				flag_n <= alu_y[`PROC_XLEN-1];
			end
			if (is_halt) begin
				halted <= 1'b1;
			end
		end
	end

	always_comb begin
		case (ex_payload.op)
			OP_BZ: taken = flag_z;
			OP_BNZ: taken = !flag_z;
			OP_BN: taken = flag_n;
			default: taken = 1'b0;
		endcase
	end

	// HALT also redirects back onto itself. That flushes the younger
	// instruction and parks the pc on the HALT.
	assign redirect = ex_valid && (taken || is_halt);
	assign redirect_pc = is_halt ? ex_payload.pc :
		ex_payload.pc + imem_addr_t'(1) + ex_payload.imm[`PROC_IMEM_AW-1:0];

	// ----------------------------------------------------------------------
	// Data memory
	// ----------------------------------------------------------------------

	assign mem_addr = alu_y[`PROC_DMEM_AW-1:0];
	assign load_word = dmem[mem_addr];
	assign dbg_data = dmem[dbg_addr];

	always_ff @(posedge CLK) begin
		if (ex_valid && (ex_payload.op == OP_SW)) begin
			dmem[mem_addr] <= fwd_rt;
		end
	end

	assign res_valid = ex_valid;

	always_comb begin
		res_payload.wr = is_alu || (ex_payload.op == OP_LW);
		res_payload.rd = ex_payload.rd;
		res_payload.value = (ex_payload.op == OP_LW) ? load_word : alu_y;
	end

endmodule

`default_nettype wire

/* hdl/fetch_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "processor_cfg.svh"

module fetch_decode import processor_pkg::*; (
	input  wire             CLK,
	input  wire             rst,
	input  wire             im_we,
	input  wire imem_addr_t im_addr,
	input  wire word_t      im_data,
	input  wire             redirect,
	input  wire imem_addr_t redirect_pc,
	input  wire             halted,
	output reg_idx_t        rs_idx,
	output reg_idx_t        rt_idx,
	input  wire word_t      rs_val,
	input  wire word_t      rt_val,
	output logic            dec_valid,
	output ex_payload_t     dec_payload
);

	word_t imem [`PROC_IMEM_DEPTH];
	imem_addr_t pc;
	word_t instr;

	// ----------------------------------------------------------------------
	// Instruction memory and program counter
	// ----------------------------------------------------------------------

	// The load port stays open at all times and also during reset.
	always_ff @(posedge CLK) begin
		if (im_we) begin
			imem[im_addr] <= im_data;
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			pc <= '0;
		end else if (redirect) begin
			pc <= redirect_pc;
		end else if (!halted) begin
			pc <= pc + imem_addr_t'(1);
		end
	end

	assign instr = imem[pc];

	// ----------------------------------------------------------------------
	// Decode
	// ----------------------------------------------------------------------

	assign rs_idx = instr[23:20];
	assign rt_idx = instr[19:16];

	always_comb begin
		dec_payload.op = opcode_e'(instr[31:28]);
		dec_payload.rd = instr[27:24];
		dec_payload.rs = rs_idx;
		dec_payload.rt = rt_idx;
		dec_payload.rs_val = rs_val;
		dec_payload.rt_val = rt_val;
		// Sign-extend the 16-bit immediate.
		dec_payload.imm = {{(`PROC_XLEN-16){instr[15]}}, instr[15:0]};
		dec_payload.pc = pc;
	end

	// Once halted, fetch only produces bubbles.
	assign dec_valid = !halted;

endmodule

`default_nettype wire

/* hdl/register_bank.sv */
`timescale 1ns/100ps
`default_nettype none

`include "processor_cfg.svh"

module register_bank import processor_pkg::*; (
	input  wire           CLK,
	input  wire           rst,
	input  wire reg_idx_t rs_idx,
	input  wire reg_idx_t rt_idx,
	output word_t         rs_val,
	output word_t         rt_val,
	input  wire           wr_en,
	input  wire reg_idx_t wr_idx,
	input  wire word_t    wr_val
);

	word_t regs [`PROC_REGS];

	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 0; i < `PROC_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_idx] <= wr_val;
		end
	end

	// Write first. A register written this cycle reads as its new value,
	// so decode never has to wait for write-back.
	assign rs_val = (wr_en && (wr_idx == rs_idx)) ? wr_val : regs[rs_idx];
	assign rt_val = (wr_en && (wr_idx == rt_idx)) ? wr_val : regs[rt_idx];

endmodule

`default_nettype wire

/* hdl/pipe_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  wire      CLK,
	input  wire      rst,
	input  wire      flush,
	input  wire      in_valid,
	input  var       payload_t in_payload,
	output logic     out_valid,
	output payload_t out_payload
);

	// A flush turns the entry into a bubble.
	always_ff @(posedge CLK) begin
		if (rst || flush) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	// Bubbles leave the last payload in place; only valid entries load.
	always_ff @(posedge CLK) begin
		if (in_valid) begin
			out_payload <= in_payload;
		end
	end

endmodule

`default_nettype wire

/* hdl/processor_pkg.sv */
`default_nettype none

`include "processor_cfg.svh"

package processor_pkg;

	typedef logic [`PROC_XLEN-1:0] word_t;
	typedef logic [`PROC_REG_AW-1:0] reg_idx_t;
	typedef logic [`PROC_IMEM_AW-1:0] imem_addr_t;
	typedef logic [`PROC_DMEM_AW-1:0] dmem_addr_t;

	// The opcode sits in instruction bits 31 to 28.
	typedef enum logic [3:0] {
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_AND  = 4'h2,
		OP_OR   = 4'h3,
		OP_XOR  = 4'h4,
		OP_ADDI = 4'h5,
		OP_LW   = 4'h6,
		OP_SW   = 4'h7,
		OP_BZ   = 4'h8,
		OP_BNZ  = 4'h9,
		OP_BN   = 4'ha,
		OP_HALT = 4'hb
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS_B
	} alu_op_e;

	// ----------------------------------------------------------------------
	// Stage payloads
	// ----------------------------------------------------------------------

	typedef struct packed {
		opcode_e op;
		reg_idx_t rd;
		reg_idx_t rs;
		reg_idx_t rt;
		word_t rs_val;
		word_t rt_val;
		word_t imm;
		imem_addr_t pc;
	} ex_payload_t;

	typedef struct packed {
		logic wr;
		reg_idx_t rd;
		word_t value;
	} wb_payload_t;

endpackage

`default_nettype wire

/* hdl/processor_cfg.svh */
`ifndef PROCESSOR_CFG_SVH
`define PROCESSOR_CFG_SVH

// ----------------------------------------------------------------------
// Core sizes
// ----------------------------------------------------------------------

// Data and instruction words share one width.
`define PROC_XLEN 32

// Register bank.
`define PROC_REGS 16
`define PROC_REG_AW 4

// Both memories are word addressed.
`define PROC_IMEM_DEPTH 64
`define PROC_DMEM_DEPTH 64
`define PROC_IMEM_AW 6
`define PROC_DMEM_AW 6

`endif
